// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module shift_exec_tb -f tb.f -o shift_exec_sim ||
  { echo "build failed"; exit 1; }
out=$(./obj_dir/shift_exec_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// File: sim/shift_exec_tb.sv
/*
 * Testbench for the shift execution path. Dispatches random shifts from a
 * fixed seed, grants the CDB at random, and checks every granted packet
 * against a model queue. Run with the files listed in tb.f.
 */

`default_nettype none

module shift_exec_tb;
  import cpu_pkg::*;

  localparam int NUM_OPS        = 300;
  localparam int DISPATCH_LIMIT = 30000;
  localparam int DRAIN_LIMIT    = 2000;
  localparam int STALL_START    = 400;
  localparam int STALL_END      = 600;

  logic        clk;
  logic        reset;
  logic        dispatch_valid;
  shift_op_t   dispatch_op;
  logic        dispatch_ready;
  logic        cdb_valid;
  cdb_packet_t cdb;
  logic        cdb_grant;

  integer              seed;
  int                  n_accepted;
  int                  cycle;
  int                  drain_cycles;
  logic [ROB_BITS-1:0] next_rob;
  logic                accepted;
  logic                stalled;
  logic                saw_ready_low;
  logic                held_pending;
  cdb_packet_t         held_pkt;
  cdb_packet_t         model [$];

  shift_exec_top shift_exec_top_i (
    .clk            (clk),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .dispatch_ready (dispatch_ready),
    .cdb_valid      (cdb_valid),
    .cdb            (cdb),
    .cdb_grant      (cdb_grant)
  );

  always #5 clk = ~clk;

  task automatic check_packet(input cdb_packet_t got, input cdb_packet_t exp,
                              input string what);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %h expected %h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "packet mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s: got %b expected %b", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("ERROR: %s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  // reference result from the shift rule on the low bits of b
  function automatic cdb_packet_t expected_packet(input shift_op_t op);
    cdb_packet_t           pkt;
    logic [SHAMT_BITS-1:0] amt;
    amt                = op.b[SHAMT_BITS-1:0];
    pkt.dest_rob_entry = op.rob_entry;
    pkt.branch_result  = 1'b0;
    pkt.load_step1     = 1'b0;
    case (op.alu_op)
      ALU_SLL: pkt.result = op.a << amt;
      ALU_SRA: pkt.result = $signed(op.a) >>> amt;
      default: pkt.result = op.a >> amt;
    endcase
    return pkt;
  endfunction

  task automatic make_op(output shift_op_t op);
    int unsigned pick;
    op.rob_entry = next_rob;
    op.a         = $random(seed);
    op.b         = $random(seed);
    pick         = {$random(seed)} % 3;
    case (pick)
      0:       op.alu_op = ALU_SLL;
      1:       op.alu_op = ALU_SRL;
      default: op.alu_op = ALU_SRA;
    endcase
    // push some amounts to the two extremes
    pick = {$random(seed)} % 8;
    if (pick == 0) begin
      op.b[SHAMT_BITS-1:0] = '0;
    end else if (pick == 1) begin
      op.b[SHAMT_BITS-1:0] = '1;
    end
  endtask

  // called right after a rising edge
  task automatic drive_inputs();
    shift_op_t op;
    stalled = (cycle >= STALL_START) && (cycle < STALL_END);
    if (cycle == STALL_END) begin
      check_flag(saw_ready_low, 1'b1, "dispatch_ready low during cdb stall");
    end
    // a rejected operation stays on the bus
    if (dispatch_valid && !accepted) begin
      dispatch_valid <= 1'b1;
    end else if (n_accepted < NUM_OPS && ({$random(seed)} % 2 == 0)) begin
      make_op(op);
      dispatch_valid <= 1'b1;
      dispatch_op    <= op;
    end else begin
      dispatch_valid <= 1'b0;
    end
    cdb_grant <= stalled ? 1'b0 : (({$random(seed)} % 10) < 6);
  endtask

  // called at the falling edge with inputs and outputs settled
  task automatic observe_cycle();
    cdb_packet_t exp;
    if (held_pending) begin
      check_flag(cdb_valid, 1'b1, "cdb_valid held until grant");
      check_packet(cdb, held_pkt, "cdb unchanged until grant");
    end
    if (cdb_valid && cdb_grant) begin
      check_flag(model.size() != 0, 1'b1, "cdb packet with nothing outstanding");
      exp = model.pop_front();
      check_packet(cdb, exp, "cdb result");
    end
    held_pending = cdb_valid && !cdb_grant;
    held_pkt     = cdb;
    accepted     = dispatch_valid && dispatch_ready;
    if (accepted) begin
      model.push_back(expected_packet(dispatch_op));
      n_accepted = n_accepted + 1;
      next_rob   = next_rob + ROB_BITS'(1);
    end
    if (stalled && !dispatch_ready) begin
      saw_ready_low = 1'b1;
    end
    // queue, unit done state and writeback register
    check_flag(model.size() <= QUEUE_DEPTH + 2, 1'b1, "operations in flight bounded");
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op    = '0;
    cdb_grant      = 1'b0;
    seed           = 32'h7381f8a1;
    n_accepted     = 0;
    cycle          = 0;
    drain_cycles   = 0;
    next_rob       = '0;
    accepted       = 1'b0;
    stalled        = 1'b0;
    saw_ready_low  = 1'b0;
    held_pending   = 1'b0;
    held_pkt       = '0;

    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag(dispatch_ready, 1'b1, "dispatch_ready after reset");
    check_flag(cdb_valid, 1'b0, "cdb_valid after reset");

    while (n_accepted < NUM_OPS) begin
      if (cycle >= DISPATCH_LIMIT) begin
        stop_run("dispatch stopped accepting operations before all were sent");
      end else begin
        @(posedge clk);
        drive_inputs();
        @(negedge clk);
        observe_cycle();
        cycle = cycle + 1;
      end
    end

    // drain what is still in flight
    while (model.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
      observe_cycle();
      cycle        = cycle + 1;
      drain_cycles = drain_cycles + 1;
    end

    if (model.size() != 0) begin
      stop_run("results stopped arriving on the cdb before all operations completed");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: src/cdb_writeback.sv
/*
 * Writeback holding register between the shift unit and the common data
 * bus. Keeps one packet on the bus until granted and takes the next one
 * in the same cycle as the grant.
 */

`default_nettype none

module cdb_writeback (
  input  logic                 clk,
  input  logic                 reset,
  // from the shift unit
  input  logic                 fu_valid,
  input  cpu_pkg::cdb_packet_t fu_packet,
  output logic                 yumi,
  // common data bus
  output logic                 cdb_valid,
  output cpu_pkg::cdb_packet_t cdb,
  input  logic                 cdb_grant
);
  import cpu_pkg::*;

  cdb_packet_t held;
  logic        full;

  // free slot, or one freed by this cycle's grant
  assign yumi      = fu_valid && (!full || cdb_grant);
  assign cdb_valid = full;
  assign cdb       = held;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (yumi) begin
      full <= 1'b1;
    end else if (cdb_grant) begin
      // granted with nothing behind it
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (yumi) begin
      held <= fu_packet;
    end
  end

endmodule

`default_nettype wire

// File: src/cpu_pkg.sv
/*
 * Shared definitions for the shift execution path: operand and tag widths,
 * issue-queue sizing, ALU operation codes and the packets passed between
 * dispatch, the shift unit and the common data bus.
 */

`default_nettype none

package cpu_pkg;

  // datapath widths
  localparam int XLEN = 32;
  localparam int ROB_BITS = 4;
  localparam int SHAMT_BITS = 5;

  // issue queue sizing
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_BITS = $clog2(QUEUE_DEPTH + 1);

  // full ALU opcode space of which only the shifts run here
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_t;

  // one dispatched operation tagged with its ROB entry
  typedef struct packed {
    logic [ROB_BITS-1:0] rob_entry;
    alu_op_t             alu_op;
    logic [XLEN-1:0]     a;
    // amount sits in the low SHAMT_BITS
    logic [XLEN-1:0]     b;
  } shift_op_t;

  // common data bus packet
  typedef struct packed {
    logic [ROB_BITS-1:0] dest_rob_entry;
    logic [XLEN-1:0]     result;
    logic                branch_result;
    logic                load_step1;
  } cdb_packet_t;

endpackage

`default_nettype wire

// File: src/shift_exec_top.sv
/*
 * Top of the shift execution path: issue queue, iterative shift unit and
 * CDB writeback in a chain. Dispatch enters on the left, results leave
 * on the common data bus in dispatch order.
 */

`default_nettype none

module shift_exec_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 dispatch_valid,
  input  cpu_pkg::shift_op_t   dispatch_op,
  output logic                 dispatch_ready,
  output logic                 cdb_valid,
  output cpu_pkg::cdb_packet_t cdb,
  input  logic                 cdb_grant
);
  import cpu_pkg::*;

  logic        issue_valid;
  shift_op_t   issue_op;
  logic        fu_ready;
  logic        fu_valid;
  cdb_packet_t fu_packet;
  logic        wb_yumi;

  shift_issue_queue shift_issue_queue_i (
    .clk            (clk),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_op),
    .dispatch_ready (dispatch_ready),
    .issue_valid    (issue_valid),
    .issue_op       (issue_op),
    .fu_ready       (fu_ready)
  );

  shift_unit shift_unit_i (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (issue_valid),
    .op_in     (issue_op),
    .ready     (fu_ready),
    .valid_out (fu_valid),
    .out       (fu_packet),
    .yumi_in   (wb_yumi)
  );

  cdb_writeback cdb_writeback_i (
    .clk       (clk),
    .reset     (reset),
    .fu_valid  (fu_valid),
    .fu_packet (fu_packet),
    .yumi      (wb_yumi),
    .cdb_valid (cdb_valid),
    .cdb       (cdb),
    .cdb_grant (cdb_grant)
  );

endmodule

`default_nettype wire

// File: src/shift_issue_queue.sv
/*
 * In-order issue queue for shift operations. Dispatch pushes with
 * valid/ready, the oldest entry is offered to the shift unit and popped
 * on the edge where the unit takes it.
 */

`default_nettype none

module shift_issue_queue (
  input  logic               clk,
  input  logic               reset,
  // dispatch side
  input  logic               dispatch_valid,
  input  cpu_pkg::shift_op_t dispatch_op,
  output logic               dispatch_ready,
  // issue side
  output logic               issue_valid,
  output cpu_pkg::shift_op_t issue_op,
  input  logic               fu_ready
);
  import cpu_pkg::*;

  shift_op_t                 entries [QUEUE_DEPTH];
  logic [QUEUE_PTR_BITS-1:0] rd_ptr;
  logic [QUEUE_PTR_BITS-1:0] wr_ptr;
  logic [QUEUE_CNT_BITS-1:0] count;
  logic                      push;
  logic                      pop;

  // circular pointer advance
  function automatic logic [QUEUE_PTR_BITS-1:0] next_ptr(
    input logic [QUEUE_PTR_BITS-1:0] ptr
  );
    logic [QUEUE_PTR_BITS-1:0] nxt;
    if (ptr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + QUEUE_PTR_BITS'(1);
    end
    return nxt;
  endfunction

  // full and empty come from the count only
  assign dispatch_ready = (count != QUEUE_CNT_BITS'(QUEUE_DEPTH));
  assign issue_valid    = (count != '0);
  assign issue_op       = entries[rd_ptr];

  assign push = dispatch_valid && dispatch_ready;
  assign pop  = issue_valid && fu_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + QUEUE_CNT_BITS'(1);
        2'b01:   count <= count - QUEUE_CNT_BITS'(1);
        default: count <= count;
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= dispatch_op;
    end
  end

endmodule

`default_nettype wire

// File: src/shift_unit.sv
/*
 * Iterative shift functional unit. Takes one operation in idle, moves the
 * operand one bit per cycle in the shift state, then holds the finished
 * CDB packet in done until the writeback stage takes it with yumi.
 */

`default_nettype none

module shift_unit (
  input  logic                 clk,
  input  logic                 reset,
  // from the issue queue
  input  logic                 valid_in,
  input  cpu_pkg::shift_op_t   op_in,
  output logic                 ready,
  // to writeback
  output logic                 valid_out,
  output cpu_pkg::cdb_packet_t out,
  input  logic                 yumi_in
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    s_idle  = 2'b00,
    s_shift = 2'b10,
    s_done  = 2'b11
  } state_t;

  state_t                state;
  state_t                state_next;
  logic [XLEN-1:0]       operand;
  logic [XLEN-1:0]       operand_shifted;
  logic [SHAMT_BITS-1:0] bits_left;
  logic [ROB_BITS-1:0]   rob_tag;
  alu_op_t               op_kind;
  logic                  accept;
  logic                  shift_en;

  assign ready     = (state == s_idle);
  assign valid_out = (state == s_done);
  assign accept    = ready && valid_in;
  // a zero amount still spends one cycle here but never moves
  assign shift_en  = (state == s_shift) && (bits_left != '0);

  // one-bit step for the latched operation
  always_comb begin
    case (op_kind)
      ALU_SLL: operand_shifted = {operand[XLEN-2:0], 1'b0};
      ALU_SRA: operand_shifted = {operand[XLEN-1], operand[XLEN-1:1]};
      default: operand_shifted = {1'b0, operand[XLEN-1:1]};
    endcase
  end

  always_comb begin
    case (state)
      s_idle: begin
        state_next = valid_in ? s_shift : s_idle;
      end
      s_shift: begin
        // last step is the one taken with one bit left
        state_next = (bits_left <= SHAMT_BITS'(1)) ? s_done : s_shift;
      end
      s_done: begin
        state_next = yumi_in ? s_idle : s_done;
      end
      default: begin
        state_next = s_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  // operand, counter and latched tag
  always_ff @(posedge clk) begin
    if (accept) begin
      operand   <= op_in.a;
      bits_left <= op_in.b[SHAMT_BITS-1:0];
      rob_tag   <= op_in.rob_entry;
      op_kind   <= op_in.alu_op;
    end else if (shift_en) begin
      operand   <= operand_shifted;
      bits_left <= bits_left - SHAMT_BITS'(1);
    end
  end

  // no branch or load results from this unit
  assign out.dest_rob_entry = rob_tag;
  assign out.result         = operand;
  assign out.branch_result  = 1'b0;
  assign out.load_step1     = 1'b0;

endmodule

`default_nettype wire

// File: tb.f
src/cpu_pkg.sv
src/shift_issue_queue.sv
src/shift_unit.sv
src/cdb_writeback.sv
src/shift_exec_top.sv
sim/shift_exec_tb.sv
